//--- common/spd_settings.svh
// constants for the SPD report path
// the message width must stay below 32 characters because the length field is 5 bits
// the scan starts at 1 because address 0 is the I2C general call
`ifndef SPD_SETTINGS_SVH
`define SPD_SETTINGS_SVH

// longest message in characters
`define SPD_TEXT_CHARS 30

// SPD bytes 0 up to this index are read
`define SPD_LAST_BYTE 63

`define SPD_SCAN_START 1

// byte 2 value that identifies DDR3 SDRAM
`define SPD_DDR3_CODE 8'h0B

// medium timebase is printed in ps, so the ns dividend is scaled up
`define SPD_MTB_SCALE 1000

`endif

//--- common/spd_pkg.sv
// word types shared by the SPD sequencer, formatter and UART sender
// message text is right-aligned, so the first character sits at byte len-1
// and the last character in bits 7:0
`include "spd_settings.svh"

package spd_pkg;

    ////////////////////////////////
    // I2C side
    ////////////////////////////////

    // one read request to the external I2C master
    typedef struct packed {
        logic [6:0] dev_addr;   // 7-bit device address
        logic [7:0] reg_addr;   // register (SPD byte) address
    } i2c_req_t;

    // one SPD byte as read back
    typedef struct packed {
        logic [5:0] idx;        // byte index 0..63
        logic [7:0] data;
    } spd_byte_t;

    ////////////////////////////////
    // UART side
    ////////////////////////////////

    // one line of report text
    typedef struct packed {
        logic [`SPD_TEXT_CHARS*8-1:0] text;
        logic [4:0]                   len;  // number of characters used
    } text_msg_t;

endpackage

//--- spd_seq/spd_sequencer.sv
// address scan and SPD byte read control
// assumes the I2C master raises busy the cycle after o_i2c_en and keeps
// nack and rdata valid from the falling edge of busy until the next request
// an absent SPD device makes the scan wrap and run forever
// a NACK in the byte phase is fatal until the next reset
`timescale 1ns/1ps
`include "spd_settings.svh"

module spd_sequencer import spd_pkg::*; (
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic       i_i2c_busy,
    input  logic       i_i2c_nack,
    input  logic [7:0] i_i2c_rdata,
    input  logic       i_msg_done,
    input  logic       i_byte_skip,
    output logic       o_i2c_en,
    output i2c_req_t   o_i2c_req,
    output logic       o_addr_found,
    output logic [6:0] o_found_addr,
    output logic       o_byte_valid,
    output spd_byte_t  o_byte,
    output logic       o_addr_done,
    output logic       o_read_done,
    output logic       o_spd_error
);

    typedef enum logic [2:0] {
        ST_SCAN_REQ,
        ST_SCAN_WAIT,
        ST_ADDR_MSG,
        ST_READ_REQ,
        ST_READ_WAIT,
        ST_BYTE_MSG,
        ST_DONE,
        ST_ERROR
    } seq_state_t;

    seq_state_t state;
    logic [6:0] dev_addr;   // probe address, then the found address
    logic [5:0] byte_idx;
    logic       xfer_end;

    // busy is still low in the pulse cycle itself, so that cycle is excluded
    assign xfer_end = !i_i2c_busy && !o_i2c_en;

    // register 0 during the scan, the byte index afterwards
    assign o_i2c_req    = '{dev_addr: dev_addr,
                            reg_addr: o_addr_done ? {2'b00, byte_idx} : 8'h00};
    assign o_found_addr = dev_addr;
    assign o_byte       = '{idx: byte_idx, data: i_i2c_rdata};

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state        <= ST_SCAN_REQ;
            dev_addr     <= 7'(`SPD_SCAN_START);
            byte_idx     <= '0;
            o_i2c_en     <= 1'b0;
            o_addr_found <= 1'b0;
            o_byte_valid <= 1'b0;
            o_addr_done  <= 1'b0;
            o_read_done  <= 1'b0;
            o_spd_error  <= 1'b0;
        end else begin
            o_i2c_en     <= 1'b0;   // all three are single-cycle pulses
            o_addr_found <= 1'b0;
            o_byte_valid <= 1'b0;
            case (state)
                ST_SCAN_REQ: if (!i_i2c_busy) begin
                    o_i2c_en <= 1'b1;
                    state    <= ST_SCAN_WAIT;
                end
                ST_SCAN_WAIT: if (xfer_end) begin
                    if (i_i2c_nack) begin // nobody home, try the next address
                        dev_addr <= (dev_addr == 7'h7F) ? 7'(`SPD_SCAN_START)
                                                        : dev_addr + 7'd1;
                        state    <= ST_SCAN_REQ;
                    end else begin
                        o_addr_found <= 1'b1;
                        state        <= ST_ADDR_MSG;
                    end
                end
                ST_ADDR_MSG: if (i_msg_done) begin
                    o_addr_done <= 1'b1;
                    state       <= ST_READ_REQ;
                end
                ST_READ_REQ: if (!i_i2c_busy) begin
                    o_i2c_en <= 1'b1;
                    state    <= ST_READ_WAIT;
                end
                ST_READ_WAIT: if (xfer_end) begin
                    if (i_i2c_nack) begin
                        o_spd_error <= 1'b1;
                        state       <= ST_ERROR;
                    end else begin
                        o_byte_valid <= 1'b1;
                        state        <= ST_BYTE_MSG;
                    end
                end
                // one event in flight, wait for its line or its skip
                ST_BYTE_MSG: if (i_msg_done || i_byte_skip) begin
                    if (byte_idx == 6'(`SPD_LAST_BYTE)) begin
                        o_read_done <= 1'b1;
                        state       <= ST_DONE;
                    end else begin
                        byte_idx <= byte_idx + 6'd1;
                        state    <= ST_READ_REQ;
                    end
                end
                default: ;  // done and error are terminal
            endcase
        end
    end

    ////////////////////////////////
    // checks
    ////////////////////////////////

    // relies on the external master only raising busy after a request
    a_en_not_busy: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_i2c_en |-> !i_i2c_busy);

    a_done_xor_err: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(o_read_done && o_spd_error));

endmodule

//--- rtl/spd_report_formatter.sv
// turns the found address and SPD bytes into report lines
// every event gets exactly one response on the next cycle,
// either o_msg_valid with a line or o_byte_skip
// byte 12 relies on bytes 10 and 11 having been seen earlier in the same read
`timescale 1ns/1ps
`include "spd_settings.svh"

module spd_report_formatter import spd_pkg::*; (
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic       i_addr_found,
    input  logic [6:0] i_found_addr,
    input  logic       i_byte_valid,
    input  spd_byte_t  i_byte,
    output logic       o_msg_valid,
    output text_msg_t  o_msg,
    output logic       o_byte_skip
);

    logic [7:0]  mtb_dividend;  // from byte 10
    logic [7:0]  mtb_divisor;   // from byte 11
    logic [17:0] mtb_product;
    logic [17:0] mtb_quot;
    logic [7:0]  mtb;
    text_msg_t   msg_next;
    logic        emit;          // current event produces a line

    // upper case hex digit
    function automatic logic [7:0] hex_char(input logic [3:0] nib);
        hex_char = (nib < 4'd10) ? 8'h30 + {4'h0, nib} : 8'h37 + {4'h0, nib};
    endfunction

    // timebase in ps, truncated to the low byte for the report
    assign mtb_product = mtb_dividend * 18'(`SPD_MTB_SCALE);
    assign mtb_quot    = (mtb_divisor == 8'h00) ? '0 : mtb_product / mtb_divisor;
    assign mtb         = mtb_quot[7:0];

    ////////////////////////////////
    // line builder
    ////////////////////////////////

    always_comb begin
        msg_next = '0;
        emit     = 1'b0;
        if (i_addr_found) begin
            emit          = 1'b1;
            msg_next.text = {"I2C Address: 0x", hex_char({1'b0, i_found_addr[6:4]}),
                             hex_char(i_found_addr[3:0]), 8'h0A};
            msg_next.len  = 5'd18;
        end else if (i_byte_valid) begin
            case (i_byte.idx)
                6'd2: begin
                    emit = 1'b1;
                    if (i_byte.data == `SPD_DDR3_CODE) begin
                        msg_next.text = {"DRAM Type: DDR3 SDRAM", 8'h0A};
                        msg_next.len  = 5'd22;
                    end else begin
                        msg_next.text = {"DRAM Type: NOT DDR3!", 8'h0A};
                        msg_next.len  = 5'd21;
                    end
                end
                6'd3: begin
                    emit = 1'b1;
                    case (i_byte.data)
                        8'h00: begin
                            msg_next.text = {"Module Type: Undefined!", 8'h0A};
                            msg_next.len  = 5'd24;
                        end
                        8'h01: begin
                            msg_next.text = {"Module Type: RDIMM", 8'h0A};
                            msg_next.len  = 5'd19;
                        end
                        8'h02: begin
                            msg_next.text = {"Module Type: UDIMM", 8'h0A};
                            msg_next.len  = 5'd19;
                        end
                        8'h03: begin
                            msg_next.text = {"Module Type: SO-DIMM", 8'h0A};
                            msg_next.len  = 5'd21;
                        end
                        default: emit = 1'b0;   // unknown module types are not reported
                    endcase
                end
                6'd8: if (!i_byte.data[2]) begin // lane count 1, 2, 4 or 8
                    emit          = 1'b1;
                    msg_next.text = {"BYTE_LANES: ", 8'h30 + (8'd1 << i_byte.data[1:0]),
                                     8'h0A};
                    msg_next.len  = 5'd14;
                end
                6'd12: begin
                    emit          = 1'b1;
                    msg_next.text = {"mtb: 0x", hex_char(mtb[7:4]), hex_char(mtb[3:0]),
                                     " (ps)", 8'h0A};
                    msg_next.len  = 5'd15;
                end
                6'd18: begin
                    emit          = 1'b1;
                    msg_next.text = {"TRCD: mtb * 0x", hex_char(i_byte.data[7:4]),
                                     hex_char(i_byte.data[3:0]), 8'h0A};
                    msg_next.len  = 5'd17;
                end
                default: emit = 1'b0;
            endcase
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_msg_valid <= 1'b0;
            o_byte_skip <= 1'b0;
        end else begin
            o_msg_valid <= emit;
            o_byte_skip <= i_byte_valid && !emit;
        end
    end

    always_ff @(posedge i_clk) begin
        if (emit)
            o_msg <= msg_next;
        if (i_byte_valid && i_byte.idx == 6'd10)
            mtb_dividend <= i_byte.data;
        if (i_byte_valid && i_byte.idx == 6'd11)
            mtb_divisor <= i_byte.data;
    end

    ////////////////////////////////
    // checks
    ////////////////////////////////

    // the address event has priority and would hide a byte event
    a_one_event: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(i_addr_found && i_byte_valid));

    a_msg_xor_skip: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(o_msg_valid && o_byte_skip));

endmodule

//--- rtl/uart_text_sender.sv
// sends one report line to the UART core, first character first
// a new message is only accepted while idle
// each character waits for busy to rise and fall, so a long busy only stretches the line
`timescale 1ns/1ps

module uart_text_sender import spd_pkg::*; (
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic       i_msg_valid,
    input  text_msg_t  i_msg,
    input  logic       i_tx_busy,
    output logic       o_tx_en,
    output logic [7:0] o_tx_data,
    output logic       o_msg_done
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SEND,
        ST_WAIT_RISE,
        ST_WAIT_FALL
    } tx_state_t;

    tx_state_t  state;
    text_msg_t  msg_q;
    logic [4:0] char_idx;   // counts down to the last character

    // stays stable through the tx_en cycle
    assign o_tx_data = msg_q.text[{char_idx, 3'b000} +: 8];

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state      <= ST_IDLE;
            char_idx   <= '0;
            o_tx_en    <= 1'b0;
            o_msg_done <= 1'b0;
        end else begin
            o_tx_en    <= 1'b0;
            o_msg_done <= 1'b0;
            case (state)
                ST_IDLE: if (i_msg_valid) begin
                    char_idx <= i_msg.len - 5'd1;
                    state    <= ST_SEND;
                end
                ST_SEND: if (!i_tx_busy) begin
                    o_tx_en <= 1'b1;
                    state   <= ST_WAIT_RISE;
                end
                ST_WAIT_RISE: if (i_tx_busy)
                    state <= ST_WAIT_FALL;
                ST_WAIT_FALL: if (!i_tx_busy) begin
                    if (char_idx == 5'd0) begin
                        o_msg_done <= 1'b1;
                        state      <= ST_IDLE;
                    end else begin
                        char_idx <= char_idx - 5'd1;
                        state    <= ST_SEND;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == ST_IDLE && i_msg_valid)
            msg_q <= i_msg;
    end

    a_tx_en_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_tx_en |=> !o_tx_en);

endmodule

//--- rtl/spd_reader.sv
// SPD reader top level
// the I2C master and the UART serializer are external cores
// driven through plain enable, busy and data levels
`timescale 1ns/1ps

module spd_reader import spd_pkg::*; (
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic       i_i2c_busy,
    input  logic       i_i2c_nack,
    input  logic [7:0] i_i2c_rdata,
    input  logic       i_tx_busy,
    output logic       o_i2c_en,
    output i2c_req_t   o_i2c_req,
    output logic       o_tx_en,
    output logic [7:0] o_tx_data,
    output logic       o_addr_done,
    output logic       o_read_done,
    output logic       o_spd_error
);

    logic       addr_found;
    logic [6:0] found_addr;
    logic       byte_valid;
    spd_byte_t  spd_byte;
    logic       msg_valid;
    text_msg_t  msg;
    logic       byte_skip;
    logic       msg_done;

    spd_sequencer u_seq (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_i2c_busy   (i_i2c_busy),
        .i_i2c_nack   (i_i2c_nack),
        .i_i2c_rdata  (i_i2c_rdata),
        .i_msg_done   (msg_done),
        .i_byte_skip  (byte_skip),
        .o_i2c_en     (o_i2c_en),
        .o_i2c_req    (o_i2c_req),
        .o_addr_found (addr_found),
        .o_found_addr (found_addr),
        .o_byte_valid (byte_valid),
        .o_byte       (spd_byte),
        .o_addr_done  (o_addr_done),
        .o_read_done  (o_read_done),
        .o_spd_error  (o_spd_error)
    );

    spd_report_formatter u_fmt (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_addr_found (addr_found),
        .i_found_addr (found_addr),
        .i_byte_valid (byte_valid),
        .i_byte       (spd_byte),
        .o_msg_valid  (msg_valid),
        .o_msg        (msg),
        .o_byte_skip  (byte_skip)
    );

    uart_text_sender u_tx (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_msg_valid  (msg_valid),
        .i_msg        (msg),
        .i_tx_busy    (i_tx_busy),
        .o_tx_en      (o_tx_en),
        .o_tx_data    (o_tx_data),
        .o_msg_done   (msg_done)
    );

endmodule

//--- verif/spd_reader_tb.sv
// directed testbench for the SPD reader
// models the external I2C master with one SPD slave, and the UART core
// I2C transfers hold busy for a fixed count, UART characters for a random 1 to 8 cycles
// expected report text is rebuilt here from the report line rules
`timescale 1ns/1ps
`include "spd_settings.svh"

module spd_reader_tb import spd_pkg::*; ();

    localparam int     CLK_PERIOD  = 20;
    localparam int     I2C_BUSY    = 3;                        // busy cycles per transfer
    localparam int     NUM_RUNS    = 7;
    localparam int     REQ_CYCLES  = I2C_BUSY + 4;
    localparam int     CHAR_CYCLES = `SPD_TEXT_CHARS * (8 + 3);
    localparam int     WAIT_LIMIT  = 128 * (REQ_CYCLES + CHAR_CYCLES);   // cycles per wait
    localparam longint WDOG_NS     = 2 * NUM_RUNS * WAIT_LIMIT * CLK_PERIOD;

    logic       i_clk = 1'b0;
    logic       i_rst_n;
    logic       i_i2c_busy;
    logic       i_i2c_nack;
    logic [7:0] i_i2c_rdata;
    logic       i_tx_busy;
    logic       o_i2c_en;
    i2c_req_t   o_i2c_req;
    logic       o_tx_en;
    logic [7:0] o_tx_data;
    logic       o_addr_done;
    logic       o_read_done;
    logic       o_spd_error;

    logic [7:0] spd_image [64];     // SPD contents of the modeled slave
    logic [6:0] spd_addr;
    int         nack_byte;          // read-phase byte that gets a NACK, -1 for none
    i2c_req_t   req_log [$];
    bit         phase_log [$];      // o_addr_done seen with each request
    logic [7:0] tx_log [$];

    always #(CLK_PERIOD / 2) i_clk = ~i_clk;

    spd_reader dut0 (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_i2c_busy  (i_i2c_busy),
        .i_i2c_nack  (i_i2c_nack),
        .i_i2c_rdata (i_i2c_rdata),
        .i_tx_busy   (i_tx_busy),
        .o_i2c_en    (o_i2c_en),
        .o_i2c_req   (o_i2c_req),
        .o_tx_en     (o_tx_en),
        .o_tx_data   (o_tx_data),
        .o_addr_done (o_addr_done),
        .o_read_done (o_read_done),
        .o_spd_error (o_spd_error)
    );

    //////////////////////////////
    // bus models
    //////////////////////////////

    // busy rises the cycle after the request pulse
    always begin : i2c_model
        i2c_req_t req;
        @(negedge i_clk);
        if (o_i2c_en) begin
            req = o_i2c_req;
            req_log.push_back(req);
            phase_log.push_back(o_addr_done);
            @(negedge i_clk);
            i_i2c_busy = 1'b1;
            repeat (I2C_BUSY) @(negedge i_clk);
            i_i2c_busy  = 1'b0;
            i_i2c_nack  = (req.dev_addr != spd_addr) ||
                          (o_addr_done && nack_byte == int'(req.reg_addr));
            i_i2c_rdata = spd_image[req.reg_addr[5:0]];
        end
    end

    always begin : uart_model
        int hold;
        @(negedge i_clk);
        if (o_tx_en) begin
            tx_log.push_back(o_tx_data);
            hold      = 1 + int'($urandom % 8);
            i_tx_busy = 1'b1;
            repeat (hold) @(negedge i_clk);
            i_tx_busy = 1'b0;
        end
    end

    //////////////////////////////
    // helpers
    //////////////////////////////

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
            $display("Simulation failed");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "stopping on error");
    endtask

    // sel 0 waits for the scan end, sel 1 for the read end or the error stop
    task automatic wait_for_flag(input int sel, input string what);
        int n;
        n = 0;
        while (!((sel == 0) ? o_addr_done : (o_read_done || o_spd_error))) begin
            @(negedge i_clk);
            n++;
            if (n > WAIT_LIMIT)
                abort_run({"timed out waiting for ", what});
        end
    endtask

    task automatic apply_reset();
        @(negedge i_clk);
        i_rst_n = 1'b0;
        repeat (5) @(negedge i_clk);
        while (i_tx_busy || i_i2c_busy) @(negedge i_clk);  // let the models go idle
        req_log.delete();
        phase_log.delete();
        tx_log.delete();
        i_rst_n = 1'b1;
    endtask

    task automatic load_image(input logic [7:0] dram, input logic [7:0] module_type,
                              input logic [7:0] lanes, input logic [7:0] dividend,
                              input logic [7:0] divisor, input logic [7:0] trcd);
        for (int i = 0; i < 64; i++)
            spd_image[i] = 8'(i * 37 + 5);
        spd_image[2]  = dram;
        spd_image[3]  = module_type;
        spd_image[8]  = lanes;
        spd_image[10] = dividend;
        spd_image[11] = divisor;
        spd_image[18] = trcd;
    endtask

    function automatic string hex2(input logic [7:0] v);
        string digits;
        digits = "0123456789ABCDEF";
        hex2   = $sformatf("%c%c", digits[v[7:4]], digits[v[3:0]]);
    endfunction

    // report text for the current image, line by line
    function automatic string expected_report(input logic [6:0] addr);
        string      s;
        logic [7:0] mtb;
        s = {"I2C Address: 0x", hex2({1'b0, addr}), "\n"};
        if (spd_image[2] == `SPD_DDR3_CODE)
            s = {s, "DRAM Type: DDR3 SDRAM\n"};
        else
            s = {s, "DRAM Type: NOT DDR3!\n"};
        case (spd_image[3])
            8'd0:    s = {s, "Module Type: Undefined!\n"};
            8'd1:    s = {s, "Module Type: RDIMM\n"};
            8'd2:    s = {s, "Module Type: UDIMM\n"};
            8'd3:    s = {s, "Module Type: SO-DIMM\n"};
            default: ;
        endcase
        s   = {s, $sformatf("BYTE_LANES: %0d\n", 1 << spd_image[8][2:0])};
        mtb = 8'((spd_image[10] * `SPD_MTB_SCALE) / spd_image[11]);   // truncated to a byte
        s   = {s, "mtb: 0x", hex2(mtb), " (ps)\n"};
        s   = {s, "TRCD: mtb * 0x", hex2(spd_image[18]), "\n"};
        return s;
    endfunction

    task automatic check_text(input string exp);
        check("tx character count", tx_log.size(), exp.len());
        foreach (tx_log[i])
            check($sformatf("o_tx_data[char %0d]", i), tx_log[i], exp[i]);
    endtask

    task automatic check_scan(input logic [6:0] addr);
        int k;
        k = 0;
        foreach (req_log[i]) begin
            if (!phase_log[i]) begin
                check("o_i2c_req.dev_addr (scan)", req_log[i].dev_addr, `SPD_SCAN_START + k);
                check("o_i2c_req.reg_addr (scan)", req_log[i].reg_addr, 0);
                k++;
            end
        end
        check("scan probe count", k, addr - `SPD_SCAN_START + 1);
    endtask

    task automatic check_reads(input logic [6:0] addr, input int last);
        int k;
        k = 0;
        foreach (req_log[i]) begin
            if (phase_log[i]) begin
                check("o_i2c_req.dev_addr (read)", req_log[i].dev_addr, addr);
                check("o_i2c_req.reg_addr (read)", req_log[i].reg_addr, k);
                k++;
            end
        end
        check("read request count", k, last + 1);
    endtask

    //////////////////////////////
    // tests
    //////////////////////////////

    task automatic test_reset_values();
        apply_reset();
        check("o_i2c_en", o_i2c_en, 0);
        check("o_tx_en", o_tx_en, 0);
        check("o_addr_done", o_addr_done, 0);
        check("o_read_done", o_read_done, 0);
        check("o_spd_error", o_spd_error, 0);
    endtask

    task automatic test_addr_scan();
        spd_addr = 7'h30;
        load_image(8'h0B, 8'd2, 8'd3, 8'd1, 8'd8, 8'h69);
        apply_reset();
        wait_for_flag(0, "o_addr_done after the scan");
        check_scan(7'h30);
        check_text("I2C Address: 0x30\n");
    endtask

    task automatic test_full_report();
        spd_addr = 7'h50;
        load_image(8'h0B, 8'd2, 8'd3, 8'd1, 8'd8, 8'h69);
        apply_reset();
        wait_for_flag(1, "the end of the SPD read");
        check("o_read_done", o_read_done, 1);
        check("o_spd_error", o_spd_error, 0);
        check_scan(7'h50);
        check_reads(7'h50, `SPD_LAST_BYTE);
        check_text({"I2C Address: 0x50\n", "DRAM Type: DDR3 SDRAM\n", "Module Type: UDIMM\n",
                    "BYTE_LANES: 8\n", "mtb: 0x7D (ps)\n", "TRCD: mtb * 0x69\n"});
    endtask

    task automatic test_random_image();
        logic [7:0] dram;
        logic [7:0] lanes;
        spd_addr = 7'(1 + $urandom % 'h77);
        for (int r = 0; r < 3; r++) begin
            dram = 8'($urandom);
            if (dram == `SPD_DDR3_CODE)
                dram = dram + 8'd1;
            lanes = (8'($urandom) & 8'hF8) | 8'($urandom % 4);
            load_image(dram, (r == 0) ? 8'd3 : 8'(r - 1), lanes,
                       8'(1 + $urandom % 4), 8'(1 + $urandom % 15), 8'($urandom));
            apply_reset();
            wait_for_flag(1, "the end of the SPD read");
            check("o_read_done", o_read_done, 1);
            check("o_spd_error", o_spd_error, 0);
            check_scan(spd_addr);
            check_reads(spd_addr, `SPD_LAST_BYTE);
            check_text(expected_report(spd_addr));
        end
    endtask

    task automatic test_read_nack();
        spd_addr  = 7'h52;
        nack_byte = 5;
        load_image(8'h0B, 8'd1, 8'd2, 8'd1, 8'd8, 8'h55);
        apply_reset();
        wait_for_flag(1, "the error stop after a NACK");
        check("o_spd_error", o_spd_error, 1);
        check("o_read_done", o_read_done, 0);
        check_reads(7'h52, 5);
        repeat (200) begin
            @(negedge i_clk);
            check("o_i2c_en after NACK", o_i2c_en, 0);
            check("o_read_done after NACK", o_read_done, 0);
        end
        nack_byte = -1;
    endtask

    initial begin
        void'($urandom(49));
        i_rst_n     = 1'b0;
        i_i2c_busy  = 1'b0;
        i_i2c_nack  = 1'b0;
        i_i2c_rdata = 8'h00;
        i_tx_busy   = 1'b0;
        spd_addr    = 7'h50;
        nack_byte   = -1;
        load_image(8'h0B, 8'd2, 8'd3, 8'd1, 8'd8, 8'h69);
        test_reset_values();
        test_addr_scan();
        test_full_report();
        test_random_image();
        test_read_nack();
        $display("Simulation passed");
        $finish;
    end

    // bound on the whole run
    initial begin
        #(WDOG_NS);
        $display("timeout: the tests did not finish within %0d ns", WDOG_NS);
        $display("Simulation failed");
        $fatal(1, "watchdog expired");
    end

endmodule

//--- spd_reader.f
+incdir+common
common/spd_pkg.sv
spd_seq/spd_sequencer.sv
rtl/spd_report_formatter.sv
rtl/uart_text_sender.sv
rtl/spd_reader.sv
verif/spd_reader_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the SPD reader testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module spd_reader_tb -f spd_reader.f -o sim_spd_reader
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_spd_reader > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Simulation failed" "$LOG"; then
    echo "result: FAIL"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi
if ! grep -q "Simulation passed" "$LOG"; then
    echo "no pass line in $LOG"
    exit 1
fi
echo "result: PASS"
exit 0
